//--- snes_mem_defs.svh
// Memory glue widths, reset delay and SDRAM address constants
`ifndef SNES_MEM_DEFS_SVH
`define SNES_MEM_DEFS_SVH

// Core-side address widths
`define SNES_ROM_AW 24
`define WRAM_AW 17
`define BSRAM_AW 20
`define VRAM_AW 16

// VRAM duplicate check ignores the top bit
`define VRAM_CMP_AW 15

// SDRAM byte address width
`define SDRAM_AW 23

// 7E,7F banks sit at the top of SDRAM, 128KB
`define WRAM_BASE 6'b111111

// ROM type class that reads BSRAM without RD_N
`define ROM_TYPE_BSRAM_RD 4'hC

// Cycles the core stays in reset after resetn rises
`define RESET_CYCLES 16

`endif

//--- snes_bus_pkg.sv
// Console core memory bus bundles, one struct per memory
`include "snes_mem_defs.svh"

package snes_bus_pkg;

    typedef struct packed {
        logic [`SNES_ROM_AW-1:0] addr;
        logic                    ce_n;
        logic                    word;      // 16-bit fetch
    } rom_bus_t;

    typedef struct packed {
        logic [`WRAM_AW-1:0] addr;
        logic [7:0]          d;
        logic                ce_n;
        logic                rd_n;
        logic                we_n;
    } wram_bus_t;

    typedef struct packed {
        logic [`BSRAM_AW-1:0] addr;
        logic [7:0]           d;
        logic                 ce_n;
        logic                 rd_n;
        logic                 we_n;
    } bsram_bus_t;

    // One VRAM channel; the PPU drives two of them
    typedef struct packed {
        logic [`VRAM_AW-1:0] addr;
        logic                we_n;
    } vram_bus_t;

    typedef struct packed {
        logic [15:0] addr;
        logic        ce_n;
        logic        oe_n;
    } aram_bus_t;

endpackage

//--- sdram_req_pkg.sv
// Request bundles going to the shared SDRAM controller
`include "snes_mem_defs.svh"

package sdram_req_pkg;

    // CPU port, shared by loader, ROM and WRAM
    typedef struct packed {
        logic [`SDRAM_AW-1:0] addr;
        logic [15:0]          din;
        logic [1:0]           ds;       // Byte strobes, [1] is upper
        logic                 port;     // 0 ROM, 1 WRAM
        logic                 rd;
        logic                 wr;
    } cpu_req_t;

    typedef struct packed {
        logic [`BSRAM_AW-1:0] addr;
        logic [7:0]           din;
        logic                 rd;
        logic                 wr;
    } bsram_req_t;

    typedef struct packed {
        logic rd;
        logic wr;
    } vram_req_t;

endpackage

//--- load_sequencer.sv
// Core reset delay, cartridge load tracking, loader address and run enable
`timescale 1ns/10ps
`include "snes_mem_defs.svh"

module load_sequencer (
    input  logic                 wclk,
    input  logic                 resetn,
    input  logic                 loading,
    input  logic                 loader_valid,
    input  logic                 header_finished,
    input  logic                 sdram_busy,
    input  logic                 frame_pause,
    output logic                 core_resetn,
    output logic                 loaded,
    output logic                 run_enable,
    output logic [`SDRAM_AW-1:0] loader_addr
);

    localparam int CNT_W = $clog2(`RESET_CYCLES);

    logic [CNT_W-1:0] rst_cnt;
    logic             rst_done;
    logic             loading_r;

    // Hold the core off until the delay has run out
    always_ff @(posedge wclk) begin
        if (!resetn) begin
            rst_cnt  <= '0;
            rst_done <= 1'b0;
        end else if (!rst_done) begin
            if (rst_cnt == CNT_W'(`RESET_CYCLES - 1))
                rst_done <= 1'b1;
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    assign core_resetn = rst_done & ~loading;   // Also held while a ROM streams in

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            loading_r   <= 1'b0;
            loaded      <= 1'b0;
            loader_addr <= '0;
        end else begin
            loading_r <= loading;
            if (loader_valid && header_finished)
                loader_addr <= loader_addr + 1'b1;
            if (loading && !loading_r) begin    // Load start
                loader_addr <= '0;
                loaded      <= 1'b0;
            end
            if (!loading && loading_r)          // Load end
                loaded <= 1'b1;
        end
    end

    // Core only runs with memory ready and no frame sync stall
    always_ff @(posedge wclk) begin
        if (!resetn)
            run_enable <= 1'b0;
        else
            run_enable <= loaded & ~sdram_busy & ~frame_pause;
    end

endmodule

//--- sdram_req_mux.sv
// Registered CPU-port request merge for loader, ROM and WRAM, plus BSRAM request
`timescale 1ns/10ps
`include "snes_mem_defs.svh"

module sdram_req_mux (
    input  logic                     wclk,
    input  logic                     resetn,
    input  logic                     run_enable,
    input  logic                     sysclkf_ce,
    input  logic                     sysclkr_ce,
    input  logic                     loading,
    input  logic                     loader_valid,
    input  logic                     header_finished,
    input  logic [7:0]               loader_data,
    input  logic [`SDRAM_AW-1:0]     loader_addr,
    input  logic [7:0]               rom_type,
    input  snes_bus_pkg::rom_bus_t   rom,
    input  snes_bus_pkg::wram_bus_t  wram,
    input  snes_bus_pkg::bsram_bus_t bsram,
    output sdram_req_pkg::cpu_req_t   cpu_req,
    output sdram_req_pkg::bsram_req_t bsram_req
);

    logic f_q;          // Falling-phase strobe gated by run_enable
    logic r_q;          // Rising-phase strobe
    logic wram_rd;
    logic wram_wr;
    logic bsram_rd_t;

    assign wram_rd = ~wram.ce_n & ~wram.rd_n;
    assign wram_wr = ~wram.ce_n & ~wram.we_n;

    // Some cartridge classes read BSRAM without RD_N
    assign bsram_rd_t = ~bsram.ce_n & f_q &
                        (~bsram.rd_n | (rom_type[7:4] == `ROM_TYPE_BSRAM_RD));

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            f_q     <= 1'b0;
            r_q     <= 1'b0;
            cpu_req <= '0;
        end else begin
            f_q     <= sysclkf_ce & run_enable;
            r_q     <= sysclkr_ce & run_enable;
            cpu_req <= '0;                      // Idle unless something below hits
            if (loading && loader_valid && header_finished) begin
                cpu_req.addr <= loader_addr;
                cpu_req.din  <= {loader_data, loader_data};
                cpu_req.ds   <= {loader_addr[0], ~loader_addr[0]};
                cpu_req.wr   <= 1'b1;
            end else if (!rom.ce_n && !bsram_rd_t && f_q) begin
                cpu_req.addr <= rom.addr[`SDRAM_AW-1:0];
                cpu_req.ds   <= 2'b11;          // Full word as steering picks the byte
                cpu_req.rd   <= 1'b1;
            end else if (wram_rd || wram_wr) begin
                cpu_req.addr <= {`WRAM_BASE, wram.addr};
                cpu_req.din  <= {wram.d, wram.d};
                cpu_req.ds   <= {wram.addr[0], ~wram.addr[0]};
                cpu_req.port <= 1'b1;
                cpu_req.rd   <= wram_rd & f_q;
                cpu_req.wr   <= wram_wr & r_q;
            end
        end
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            bsram_req <= '0;
        end else begin
            bsram_req.addr <= bsram.addr;
            bsram_req.din  <= bsram.d;
            bsram_req.rd   <= bsram_rd_t;
            bsram_req.wr   <= ~bsram.ce_n & ~bsram.we_n & r_q;
        end
    end

endmodule

//--- vram_read_filter.sv
// VRAM read filter: one read per new address, channel 2 staggered on collision
`timescale 1ns/10ps
`include "snes_mem_defs.svh"

module vram_read_filter (
    input  logic                      wclk,
    input  logic                      resetn,
    input  snes_bus_pkg::vram_bus_t   vram1,
    input  snes_bus_pkg::vram_bus_t   vram2,
    input  logic                      vram_oe_n,
    output sdram_req_pkg::vram_req_t  vram1_req,
    output sdram_req_pkg::vram_req_t  vram2_req
);

    logic [`VRAM_CMP_AW-1:0] vram1_addr_old;
    logic [`VRAM_CMP_AW-1:0] vram2_addr_old;
    logic                    vram_oe_n_old;
    logic                    vram1_new_read;
    logic                    vram2_new_read;
    logic                    vram2_delay;
    logic                    vram2_delay_r;

    // A read counts once: OE just went low, or the address moved
    assign vram1_new_read = ~vram_oe_n &
        (vram_oe_n_old | (vram1_addr_old != vram1.addr[`VRAM_CMP_AW-1:0]));
    assign vram2_new_read = ~vram_oe_n &
        (vram_oe_n_old | (vram2_addr_old != vram2.addr[`VRAM_CMP_AW-1:0]));

    // Two different addresses at once, push channel 2 back a cycle
    assign vram2_delay = vram1_new_read & vram2_new_read & (vram1.addr != vram2.addr);

    always_ff @(posedge wclk) begin
        vram1_addr_old <= vram1.addr[`VRAM_CMP_AW-1:0];
        vram2_addr_old <= vram2.addr[`VRAM_CMP_AW-1:0];
    end

    always_ff @(posedge wclk) begin
        if (!resetn) begin
            vram_oe_n_old <= 1'b1;
            vram2_delay_r <= 1'b0;
        end else begin
            vram_oe_n_old <= vram_oe_n;
            vram2_delay_r <= vram2_delay;
        end
    end

    assign vram1_req.rd = vram1_new_read;
    assign vram1_req.wr = ~vram1.we_n;
    assign vram2_req.rd = (vram2_new_read & ~vram2_delay) | vram2_delay_r;
    assign vram2_req.wr = ~vram2.we_n;

endmodule

//--- read_data_steer.sv
// Steers SDRAM read data back to ROM, WRAM and ARAM byte lanes
`timescale 1ns/10ps

module read_data_steer (
    input  logic                    wclk,
    input  logic                    resetn,
    input  snes_bus_pkg::rom_bus_t  rom,
    input  logic                    wram_addr_lsb,
    input  snes_bus_pkg::aram_bus_t aram,
    input  logic [15:0]             port0_data,
    input  logic [15:0]             port1_data,
    input  logic [15:0]             aram_data,
    output logic [15:0]             rom_q,
    output logic [7:0]              wram_q,
    output logic [7:0]              aram_q
);

    logic aram_rd;
    logic aram_lsb;     // Byte lane of the last ARAM read

    assign aram_rd = ~aram.ce_n & ~aram.oe_n;

    // Data comes back after the address has moved on
    always_ff @(posedge wclk) begin
        if (!resetn)
            aram_lsb <= 1'b0;
        else if (aram_rd)
            aram_lsb <= aram.addr[0];
    end

    // Odd byte fetch gets its byte in the low lane
    assign rom_q = (rom.word || !rom.addr[0]) ? port0_data :
                   {port0_data[7:0], port0_data[15:8]};

    assign wram_q = wram_addr_lsb ? port1_data[15:8] : port1_data[7:0];
    assign aram_q = aram_lsb ? aram_data[15:8] : aram_data[7:0];

endmodule

//--- snes_mem_top.sv
// Memory glue between the console core strobes and the SDRAM controller ports
`timescale 1ns/10ps
`include "snes_mem_defs.svh"

module snes_mem_top (
    input  logic                      wclk,
    input  logic                      resetn,
    input  logic                      loading,
    input  logic                      loader_valid,
    input  logic [7:0]                loader_data,
    input  logic                      header_finished,
    input  logic [7:0]                rom_type,
    input  logic                      sdram_busy,
    input  logic                      frame_pause,
    input  logic                      sysclkf_ce,
    input  logic                      sysclkr_ce,
    input  snes_bus_pkg::rom_bus_t    rom,
    input  snes_bus_pkg::wram_bus_t   wram,
    input  snes_bus_pkg::bsram_bus_t  bsram,
    input  snes_bus_pkg::vram_bus_t   vram1,
    input  snes_bus_pkg::vram_bus_t   vram2,
    input  logic                      vram_oe_n,
    input  snes_bus_pkg::aram_bus_t   aram,
    input  logic [15:0]               port0_data,
    input  logic [15:0]               port1_data,
    input  logic [15:0]               aram_data,
    output logic                      core_resetn,
    output logic                      loaded,
    output logic                      run_enable,
    output logic [`SDRAM_AW-1:0]      loader_addr,
    output sdram_req_pkg::cpu_req_t   cpu_req,
    output sdram_req_pkg::bsram_req_t bsram_req,
    output sdram_req_pkg::vram_req_t  vram1_req,
    output sdram_req_pkg::vram_req_t  vram2_req,
    output logic [15:0]               rom_q,
    output logic [7:0]                wram_q,
    output logic [7:0]                aram_q
);

    load_sequencer load_seq_i (
        .wclk(wclk), .resetn(resetn), .loading(loading), .loader_valid(loader_valid),
        .header_finished(header_finished), .sdram_busy(sdram_busy),
        .frame_pause(frame_pause), .core_resetn(core_resetn), .loaded(loaded),
        .run_enable(run_enable), .loader_addr(loader_addr)
    );

    sdram_req_mux req_mux_i (
        .wclk(wclk), .resetn(resetn), .run_enable(run_enable),
        .sysclkf_ce(sysclkf_ce), .sysclkr_ce(sysclkr_ce), .loading(loading),
        .loader_valid(loader_valid), .header_finished(header_finished),
        .loader_data(loader_data), .loader_addr(loader_addr), .rom_type(rom_type),
        .rom(rom), .wram(wram), .bsram(bsram),
        .cpu_req(cpu_req), .bsram_req(bsram_req)
    );

    vram_read_filter vram_filt_i (
        .wclk(wclk), .resetn(resetn), .vram1(vram1), .vram2(vram2),
        .vram_oe_n(vram_oe_n), .vram1_req(vram1_req), .vram2_req(vram2_req)
    );

    // WRAM byte select uses the live core address
    read_data_steer steer_i (
        .wclk(wclk), .resetn(resetn), .rom(rom), .wram_addr_lsb(wram.addr[0]),
        .aram(aram), .port0_data(port0_data), .port1_data(port1_data),
        .aram_data(aram_data), .rom_q(rom_q), .wram_q(wram_q), .aram_q(aram_q)
    );

endmodule

//--- tb_snes_mem_util.svh
// Testbench helpers: LFSR stimulus source, value compare and result counters
`ifndef TB_SNES_MEM_UTIL_SVH
`define TB_SNES_MEM_UTIL_SVH

int          err_cnt = 0;
int          chk_cnt = 0;
logic [31:0] lfsr_state = 32'h698f9576;

// Fibonacci LFSR, taps 32 22 2 1, one step per bit returned
function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
        fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], fb};
        v = {v[30:0], fb};
    end
    return v;
endfunction

task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    chk_cnt++;
    if (got !== exp) begin
        err_cnt++;
        $display("MISMATCH t=%0t %s got %h exp %h", $time, name, got, exp);
    end
endtask

`endif

//--- tb_snes_mem.sv
// Testbench for the memory glue that runs a table of stimulus rows against a rule model
`timescale 1ns/10ps
`include "snes_mem_defs.svh"

module tb_snes_mem;

    typedef struct packed {
        logic loading, lv, hf, busy, pause, fce, rce, voe;
        logic [7:0] ldata;
        logic [7:0] rtype;
        snes_bus_pkg::rom_bus_t   rom;
        snes_bus_pkg::wram_bus_t  wram;
        snes_bus_pkg::bsram_bus_t bsram;
        snes_bus_pkg::vram_bus_t  v1;
        snes_bus_pkg::vram_bus_t  v2;
        snes_bus_pkg::aram_bus_t  aram;
        logic [15:0] p0, p1, ad;
    } stim_t;

    typedef struct packed {
        sdram_req_pkg::cpu_req_t   cpu;
        sdram_req_pkg::bsram_req_t bs;
        logic                 run;
        logic                 ld;
        logic [`SDRAM_AW-1:0] la;
        logic                 core_rn;
        logic [1:0]  vrd;       // {ch2, ch1}
        logic [1:0]  vwr;       // {ch2, ch1}
        logic [15:0] rq;
        logic [7:0]  wq;
        logic [7:0]  aq;
    } exp_t;

    `include "tb_snes_mem_util.svh"

    logic wclk = 1'b0;
    logic resetn;
    stim_t cur;
    stim_t tbl[$];
    exp_t  exp_q[$];
    int    tid[$];
    int    limit = 0;
    int    cycles = 0;
    // Rule model state
    logic m_prev, m_loaded, m_run, m_f, m_r, m_oe, m_dl, m_lsb;
    logic [`SDRAM_AW-1:0] m_addr;
    logic [14:0] m_a1, m_a2;

    logic core_resetn, loaded, run_enable;
    logic [`SDRAM_AW-1:0] loader_addr;
    sdram_req_pkg::cpu_req_t   cpu_req;
    sdram_req_pkg::bsram_req_t bsram_req;
    sdram_req_pkg::vram_req_t  vram1_req, vram2_req;
    logic [15:0] rom_q;
    logic [7:0]  wram_q, aram_q;

    always #5 wclk = ~wclk;

    snes_mem_top dut_i (
        .wclk(wclk), .resetn(resetn), .loading(cur.loading), .loader_valid(cur.lv),
        .loader_data(cur.ldata), .header_finished(cur.hf), .rom_type(cur.rtype),
        .sdram_busy(cur.busy), .frame_pause(cur.pause), .sysclkf_ce(cur.fce),
        .sysclkr_ce(cur.rce), .rom(cur.rom), .wram(cur.wram), .bsram(cur.bsram),
        .vram1(cur.v1), .vram2(cur.v2), .vram_oe_n(cur.voe), .aram(cur.aram),
        .port0_data(cur.p0), .port1_data(cur.p1), .aram_data(cur.ad),
        .core_resetn(core_resetn), .loaded(loaded), .run_enable(run_enable),
        .loader_addr(loader_addr), .cpu_req(cpu_req), .bsram_req(bsram_req),
        .vram1_req(vram1_req), .vram2_req(vram2_req), .rom_q(rom_q), .wram_q(wram_q),
        .aram_q(aram_q)
    );

    function automatic stim_t idle();
        stim_t s;
        s = '0;
        s.rom.ce_n = 1'b1;
        s.wram = '{addr: '0, d: '0, ce_n: 1'b1, rd_n: 1'b1, we_n: 1'b1};
        s.bsram = '{addr: '0, d: '0, ce_n: 1'b1, rd_n: 1'b1, we_n: 1'b1};
        s.v1.we_n = 1'b1;
        s.v2.we_n = 1'b1;
        s.voe = 1'b1;
        s.aram = '{addr: '0, ce_n: 1'b1, oe_n: 1'b1};
        return s;
    endfunction

    // Expected values follow the timing rules before the model steps one cycle
    task automatic add_row(input int t, input stim_t s);
        exp_t e;
        logic n1, n2, dl, bsrd;
        e = '0;
        n1 = !s.voe & (m_oe | (m_a1 != s.v1.addr[14:0]));
        n2 = !s.voe & (m_oe | (m_a2 != s.v2.addr[14:0]));
        dl = n1 & n2 & (s.v1.addr != s.v2.addr);
        e.vrd = {(n2 & !dl) | m_dl, n1};
        e.vwr = {!s.v2.we_n, !s.v1.we_n};
        e.core_rn = (tbl.size() >= `RESET_CYCLES) && !s.loading;
        e.rq = (!s.rom.word && s.rom.addr[0]) ? {s.p0[7:0], s.p0[15:8]} : s.p0;
        e.wq = s.wram.addr[0] ? s.p1[15:8] : s.p1[7:0];
        e.aq = m_lsb ? s.ad[15:8] : s.ad[7:0];
        bsrd = !s.bsram.ce_n & m_f & (!s.bsram.rd_n | (s.rtype[7:4] == 4'hC));
        e.bs.addr = s.bsram.addr;
        e.bs.din = s.bsram.d;
        e.bs.rd = bsrd;
        e.bs.wr = !s.bsram.ce_n & !s.bsram.we_n & m_r;
        e.run = m_loaded & !s.busy & !s.pause;
        if (s.loading && s.lv && s.hf) begin
            e.cpu.addr = m_addr;
            e.cpu.din = {s.ldata, s.ldata};
            e.cpu.ds = {m_addr[0], !m_addr[0]};
            e.cpu.wr = 1'b1;
        end else if (!s.rom.ce_n && m_f && !bsrd) begin
            e.cpu.addr = s.rom.addr[`SDRAM_AW-1:0];
            e.cpu.ds = 2'b11;
            e.cpu.rd = 1'b1;
        end else if (!s.wram.ce_n && (!s.wram.rd_n || !s.wram.we_n)) begin
            e.cpu.addr = {6'b111111, s.wram.addr};
            e.cpu.din = {s.wram.d, s.wram.d};
            e.cpu.ds = {s.wram.addr[0], !s.wram.addr[0]};
            e.cpu.port = 1'b1;
            e.cpu.rd = !s.wram.rd_n & m_f;
            e.cpu.wr = !s.wram.we_n & m_r;
        end
        m_a1 = s.v1.addr[14:0];
        m_a2 = s.v2.addr[14:0];
        m_oe = s.voe;
        m_dl = dl;
        if (!s.aram.ce_n && !s.aram.oe_n)
            m_lsb = s.aram.addr[0];
        m_f = s.fce & m_run;
        m_r = s.rce & m_run;
        m_run = e.run;
        if (s.lv && s.hf)
            m_addr = m_addr + 1'b1;
        if (s.loading && !m_prev) begin
            m_addr = '0;
            m_loaded = 1'b0;
        end
        if (!s.loading && m_prev)
            m_loaded = 1'b1;
        m_prev = s.loading;
        e.ld = m_loaded;
        e.la = m_addr;
        tbl.push_back(s);
        exp_q.push_back(e);
        tid.push_back(t);
    endtask

    task automatic add_rows(input int t, input stim_t s, input int n);
        for (int k = 0; k < n; k++)
            add_row(t, s);
    endtask

    task automatic load_bytes(input int t, input int n);
        stim_t s;
        for (int k = 0; k < n; k++) begin
            s = idle();
            s.loading = 1'b1;
            s.lv = 1'b1;
            s.hf = 1'b1;
            s.ldata = 8'(rand_bits(8));
            add_row(t, s);
        end
    endtask

    task automatic build_table();
        stim_t s;
        stim_t f_row;
        stim_t r_row;
        {m_prev, m_loaded, m_run, m_f, m_r, m_dl, m_lsb} = '0;
        m_oe = 1'b1;
        m_addr = '0;
        m_a1 = '0;
        m_a2 = '0;
        f_row = idle();
        f_row.fce = 1'b1;
        r_row = idle();
        r_row.rce = 1'b1;
        // Test 1 covers reset and run enable
        add_rows(1, idle(), 1);
        s = idle();
        s.loading = 1'b1;
        add_rows(1, s, 2);
        add_rows(1, idle(), 3);
        s = idle();
        s.busy = 1'b1;
        add_row(1, s);
        add_rows(1, idle(), 2);
        s = idle();
        s.pause = 1'b1;
        add_row(1, s);
        add_rows(1, idle(), 2);
        // Test 2 streams loader writes and restarts the count from 0
        s = idle();
        s.loading = 1'b1;
        s.hf = 1'b1;
        add_row(2, s);
        load_bytes(2, 5);
        add_rows(2, idle(), 1);
        add_row(2, s);
        load_bytes(2, 3);
        add_rows(2, idle(), 3);
        // Test 3 covers ROM and WRAM
        s = idle();
        s.rom.ce_n = 1'b0;
        s.rom.addr = 24'(rand_bits(24));
        add_row(3, s);
        add_row(3, f_row);
        add_row(3, s);
        add_row(3, f_row);
        s = idle();
        s.wram = '{addr: 17'(rand_bits(17)), d: 8'(rand_bits(8)),
            ce_n: 1'b0, rd_n: 1'b0, we_n: 1'b1};
        add_rows(3, s, 2);
        add_row(3, r_row);
        s = idle();
        s.wram = '{addr: 17'(rand_bits(17)), d: 8'(rand_bits(8)),
            ce_n: 1'b0, rd_n: 1'b1, we_n: 1'b0};
        add_rows(3, s, 2);
        add_row(3, f_row);
        s = idle();
        s.loading = 1'b1;
        s.lv = 1'b1;
        s.hf = 1'b1;
        s.ldata = 8'(rand_bits(8));
        s.rom.ce_n = 1'b0;
        s.rom.addr = 24'(rand_bits(24));
        add_row(3, s);
        add_rows(3, idle(), 3);
        // Test 4 covers BSRAM
        for (int k = 0; k < 3; k++) begin
            add_row(4, f_row);
            s = idle();
            s.bsram.ce_n = 1'b0;
            s.bsram.addr = 20'(rand_bits(20));
            s.bsram.rd_n = (k != 0);
            s.rtype = (k == 1) ? 8'hC5 : 8'h21;
            add_row(4, s);
        end
        add_row(4, r_row);
        s = idle();
        s.bsram.ce_n = 1'b0;
        s.bsram.we_n = 1'b0;
        s.bsram.d = 8'(rand_bits(8));
        add_row(4, s);
        add_rows(4, idle(), 1);
        // Test 5 holds equal VRAM addresses and then collides two of them
        s = idle();
        s.voe = 1'b0;
        s.v1.addr = 16'(rand_bits(16));
        s.v2.addr = s.v1.addr;
        add_rows(5, s, 3);
        s.v1.addr = 16'(rand_bits(16));
        s.v2.addr = s.v1.addr ^ 16'h0104;
        add_rows(5, s, 2);
        s = idle();
        s.v1.we_n = 1'b0;
        add_row(5, s);
        s = idle();
        s.v2.we_n = 1'b0;
        add_row(5, s);
        add_rows(5, idle(), 1);
        // Test 6 covers read data steering
        for (int k = 0; k < 4; k++) begin
            s = idle();
            s.rom.addr = 24'(rand_bits(24));
            s.rom.addr[0] = k[0];
            s.rom.word = k[1];
            s.wram.addr = 17'(rand_bits(17));
            s.wram.addr[0] = k[1];
            s.p0 = 16'(rand_bits(16));
            s.p1 = 16'(rand_bits(16));
            s.ad = 16'(rand_bits(16));
            s.aram = '{addr: 16'(rand_bits(16)), ce_n: k[0], oe_n: k[0]};
            s.aram.addr[0] = k[1] ~^ k[0];     // Held lane differs from the live address
            add_row(6, s);
        end
        add_rows(6, idle(), 1);
    endtask

    always @(posedge wclk) begin
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("Timeout: run went past %0d cycles without finishing", limit);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        int err_start;
        cur = idle();
        resetn = 1'b0;
        build_table();
        limit = 2 * tbl.size() + `RESET_CYCLES;
        repeat (2) @(posedge wclk);
        #1;
        check_val("cpu_req", 64'(cpu_req), 64'h0);
        check_val("bsram_req", 64'(bsram_req), 64'h0);
        check_val("run_enable", 64'(run_enable), 64'h0);
        check_val("loaded", 64'(loaded), 64'h0);
        check_val("core_resetn", 64'(core_resetn), 64'h0);
        check_val("vram2_req.rd", 64'(vram2_req.rd), 64'h0);
        resetn = 1'b1;
        err_start = err_cnt;
        for (int i = 0; i < tbl.size(); i++) begin
            cur = tbl[i];
            @(negedge wclk);                    // Combinational outputs
            check_val("core_resetn", 64'(core_resetn), 64'(exp_q[i].core_rn));
            check_val("vram1_req.rd", 64'(vram1_req.rd), 64'(exp_q[i].vrd[0]));
            check_val("vram2_req.rd", 64'(vram2_req.rd), 64'(exp_q[i].vrd[1]));
            check_val("vram1_req.wr", 64'(vram1_req.wr), 64'(exp_q[i].vwr[0]));
            check_val("vram2_req.wr", 64'(vram2_req.wr), 64'(exp_q[i].vwr[1]));
            check_val("rom_q", 64'(rom_q), 64'(exp_q[i].rq));
            check_val("wram_q", 64'(wram_q), 64'(exp_q[i].wq));
            check_val("aram_q", 64'(aram_q), 64'(exp_q[i].aq));
            @(posedge wclk);
            #1;                                 // Registered outputs
            check_val("cpu_req", 64'(cpu_req), 64'(exp_q[i].cpu));
            check_val("bsram_req", 64'(bsram_req), 64'(exp_q[i].bs));
            check_val("run_enable", 64'(run_enable), 64'(exp_q[i].run));
            check_val("loaded", 64'(loaded), 64'(exp_q[i].ld));
            check_val("loader_addr", 64'(loader_addr), 64'(exp_q[i].la));
            if (i == tbl.size() - 1 || tid[i + 1] != tid[i]) begin
                $display("Test %0d done with %0d errors", tid[i], err_cnt - err_start);
                err_start = err_cnt;
            end
        end
        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

endmodule

//--- sim.f
+incdir+.
snes_bus_pkg.sv
sdram_req_pkg.sv
load_sequencer.sv
sdram_req_mux.sv
vram_read_filter.sv
read_data_steer.sv
snes_mem_top.sv
tb_snes_mem.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the memory glue testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f sim.f --top-module tb_snes_mem -Mdir obj_dir \
    && ./obj_dir/Vtb_snes_mem > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or run failed"; exit 1; }
cat sim.log
grep -q "FAIL: see errors above" sim.log && exit 1 || exit 0
